// File: src/obj_pkg.sv
package obj_pkg;

    // object table
    localparam int obj_count  = 32;
    localparam int obj_tbl_aw = 5;
    localparam int obj_tbl_dw = 32;

    // object geometry
    localparam int obj_height = 16;     // lines per object
    localparam int obj_ysub_w = 4;
    localparam int obj_pos_w  = 8;      // x and y

    // buffer write offset, compensates the read pipeline
    localparam int obj_hoffset = 6;

    // table entry fields, lsb positions
    localparam int obj_y_lsb     = 0;
    localparam int obj_x_lsb     = 8;
    localparam int obj_code_lsb  = 16;
    localparam int obj_pal_lsb   = 25;
    localparam int obj_hflip_bit = 29;
    localparam int obj_vflip_bit = 30;

    // field and bus widths
    localparam int obj_code_w  = 9;
    localparam int obj_pal_w   = 4;
    localparam int obj_rom_aw  = 14;    // code, row, half
    localparam int obj_rom_dw  = 32;    // eight packed nibbles
    localparam int obj_buf_aw  = 8;
    localparam int obj_pxl_w   = 4;
    localparam int obj_prom_aw = obj_pal_w + obj_pxl_w;

endpackage

// File: src/obj_draw_if.sv
interface obj_draw_if import obj_pkg::*; ();

    logic                  draw;    // request level, held until busy rises
    logic [obj_pos_w-1:0]  xpos;
    logic [obj_ysub_w-1:0] ysub;    // row inside the object
    logic [obj_pal_w-1:0]  pal;
    logic                  hflip;
    logic                  vflip;
    logic [obj_code_w-1:0] code;
    logic                  busy;    // from the drawer

    // object table side
    modport scan (
        output draw, xpos, ysub, pal, hflip, vflip, code,
        input  busy
    );

    // ROM fetch side
    modport drawer (
        input  draw, xpos, ysub, pal, hflip, vflip, code,
        output busy
    );

endinterface

// File: src/obj_scan.sv
module obj_scan import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hinit,
    input  logic [obj_pos_w-1:0]  vdump,
    input  logic                  tbl_we,
    input  logic [obj_tbl_aw-1:0] tbl_addr,
    input  logic [obj_tbl_dw-1:0] tbl_data,
    obj_draw_if.scan              drw
);

    logic [obj_tbl_dw-1:0] tbl [obj_count];
    logic [obj_tbl_dw-1:0] entry;
    logic [obj_tbl_aw-1:0] idx;
    logic [obj_pos_w-1:0]  line;    // line being prepared
    logic [obj_pos_w-1:0]  diff;
    logic                  active;  // scan in progress
    logic                  granted; // current entry taken by the drawer
    logic                  hit;
    logic                  issue;
    logic                  last;

    initial begin
        for (int i = 0; i < obj_count; i++) begin
            tbl[i] = '0;
        end
    end

    // host write port
    always @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_data;
        end
    end

    assign entry = tbl[idx];
    assign diff  = line - entry[obj_y_lsb +: obj_pos_w];   // wraps mod 256
    assign hit   = diff < obj_pos_w'(obj_height);
    assign last  = idx == obj_tbl_aw'(obj_count - 1);

    // only look at a new entry while the drawer is free
    assign issue = active && !drw.draw && !drw.busy && hit && !granted;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            granted  <= 1'b0;
            drw.draw <= 1'b0;
            idx      <= '0;
            line     <= '0;
        end else if (hinit) begin
            // new line, anything unfinished is dropped
            active   <= 1'b1;
            granted  <= 1'b0;
            drw.draw <= 1'b0;
            idx      <= '0;
            line     <= vdump + obj_pos_w'(1);
        end else if (active) begin
            if (drw.draw) begin
                if (drw.busy) begin     // accepted
                    drw.draw <= 1'b0;
                    granted  <= 1'b1;
                end
            end else if (!drw.busy) begin
                if (issue) begin
                    drw.draw <= 1'b1;
                end else begin
                    // miss, or the drawer finished this entry
                    granted <= 1'b0;
                    idx     <= idx + obj_tbl_aw'(1);
                    if (last) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    // request fields, stable while draw is high
    always_ff @(posedge clk) begin
        if (issue) begin
            drw.xpos  <= entry[obj_x_lsb +: obj_pos_w];
            drw.ysub  <= diff[obj_ysub_w-1:0];
            drw.pal   <= entry[obj_pal_lsb +: obj_pal_w];
            drw.hflip <= entry[obj_hflip_bit];
            drw.vflip <= entry[obj_vflip_bit];
            drw.code  <= entry[obj_code_lsb +: obj_code_w];
        end
    end

endmodule

// File: src/obj_draw.sv
module obj_draw import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    obj_draw_if.drawer             drw,
    input  logic [obj_rom_dw-1:0]  rom_data,
    input  logic                   rom_ok,
    input  logic [obj_pxl_w-1:0]   pal_colour,
    output logic [obj_rom_aw-1:0]  rom_addr,
    output logic                   rom_cs,
    output logic [obj_prom_aw-1:0] pal_addr,
    output logic                   buf_we,
    output logic [obj_buf_aw-1:0]  buf_addr,
    output logic [obj_pxl_w-1:0]   buf_data
);

    logic                  accept;
    logic                  load;
    logic                  half;        // 0: pixels 0-7, 1: pixels 8-15
    logic [2:0]            cnt;         // pixels left in this word
    logic [obj_rom_dw-1:0] pxl_data;
    logic [obj_code_w-1:0] cur_code;
    logic [obj_ysub_w-1:0] cur_row;
    logic [obj_pal_w-1:0]  cur_pal;
    logic                  cur_hflip;
    logic [obj_buf_aw-1:0] start_addr;

    assign accept = drw.draw && !drw.busy;
    assign load   = rom_cs && rom_ok;

    // flipped objects are drawn right to left from the last column
    assign start_addr = drw.xpos + (drw.hflip ? obj_buf_aw'(obj_height - 1) : '0)
                      + obj_buf_aw'(obj_hoffset);

    assign rom_addr = {cur_code, cur_row, half};
    assign pal_addr = {cur_pal, pxl_data[obj_pxl_w-1:0]};   // leftmost nibble first
    assign buf_data = pal_colour;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            drw.busy <= 1'b0;
            rom_cs   <= 1'b0;
            buf_we   <= 1'b0;
            half     <= 1'b0;
            cnt      <= '0;
        end else if (accept) begin
            drw.busy <= 1'b1;
            rom_cs   <= 1'b1;
            half     <= 1'b0;
        end else if (load) begin
            rom_cs <= 1'b0;
            buf_we <= 1'b1;
            cnt    <= 3'(obj_height / 2 - 1);
        end else if (buf_we) begin
            cnt <= cnt - 3'd1;
            if (cnt == 3'd0) begin
                buf_we <= 1'b0;
                if (half) begin
                    drw.busy <= 1'b0;   // 16th pixel written
                end else begin
                    half   <= 1'b1;
                    rom_cs <= 1'b1;     // second word
                end
            end
        end
        // rom_cs high without rom_ok holds everything
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_code  <= drw.code;
            cur_row   <= drw.ysub ^ {obj_ysub_w{drw.vflip}};
            cur_pal   <= drw.pal;
            cur_hflip <= drw.hflip;
            buf_addr  <= start_addr;
        end else if (load) begin
            pxl_data <= rom_data;
        end else if (buf_we) begin
            pxl_data <= pxl_data >> obj_pxl_w;
            // runs straight on into the second half
            buf_addr <= cur_hflip ? buf_addr - obj_buf_aw'(1) : buf_addr + obj_buf_aw'(1);
        end
    end

endmodule

// File: src/obj_pal_prom.sv
module obj_pal_prom import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   prog_en,
    input  logic [obj_prom_aw-1:0] prog_addr,
    input  logic [obj_pxl_w-1:0]   prog_data,
    input  logic [obj_prom_aw-1:0] pal_addr,
    output logic [obj_pxl_w-1:0]   pal_colour
);

    logic [obj_pxl_w-1:0] mem [2**obj_prom_aw];

    initial begin
        for (int i = 0; i < 2**obj_prom_aw; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // async read keeps the colour in step with buf_addr
    assign pal_colour = mem[pal_addr];

endmodule

// File: src/obj_line_buf.sv
module obj_line_buf import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  hinit,
    input  logic                  lhbl,
    input  logic [8:0]            hdump,
    input  logic                  buf_we,
    input  logic [obj_buf_aw-1:0] buf_addr,
    input  logic [obj_pxl_w-1:0]  buf_data,
    output logic [obj_pxl_w-1:0]  pxl
);

    logic                     bank;     // bank being drawn, the other one is shown
    logic [obj_hoffset-2:0]   lhbl_sh;
    logic                     lhbl_dly;
    logic                     erase;
    logic [obj_buf_aw-1:0]    rd_addr;
    logic [obj_pxl_w-1:0]     rd_data [2];

    assign rd_addr  = hdump[obj_buf_aw-1:0];
    assign lhbl_dly = lhbl_sh[obj_hoffset-2];
    assign erase    = pxl_cen && lhbl_dly;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank    <= 1'b0;
            lhbl_sh <= '0;
            pxl     <= '0;
        end else begin
            if (hinit) begin
                bank <= ~bank;
            end
            if (pxl_cen) begin
                lhbl_sh <= {lhbl_sh[obj_hoffset-3:0], lhbl};
                pxl     <= rd_data[~bank];
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [obj_pxl_w-1:0] mem [2**obj_buf_aw];

        initial begin
            for (int i = 0; i < 2**obj_buf_aw; i++) begin
                mem[i] = '0;
            end
        end

        always @(posedge clk) begin
            if (bank == 1'(b)) begin
                // colour 0 is transparent
                if (buf_we && buf_data != '0) begin
                    mem[buf_addr] <= buf_data;
                end
            end else if (erase) begin
                mem[rd_addr] <= '0;     // cleared behind the read
            end
        end

        assign rd_data[b] = mem[rd_addr];
    end

endmodule

// File: src/obj_render.sv
module obj_render import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // host
    input  logic                   tbl_we,
    input  logic [obj_tbl_aw-1:0]  tbl_addr,
    input  logic [obj_tbl_dw-1:0]  tbl_data,
    input  logic                   prog_en,
    input  logic [obj_prom_aw-1:0] prog_addr,
    input  logic [obj_pxl_w-1:0]   prog_data,

    // video timing
    input  logic                   pxl_cen,
    input  logic                   hinit,
    input  logic                   lhbl,
    input  logic [8:0]             hdump,
    input  logic [obj_pos_w-1:0]   vdump,

    // graphics ROM
    output logic [obj_rom_aw-1:0]  rom_addr,
    output logic                   rom_cs,
    input  logic [obj_rom_dw-1:0]  rom_data,
    input  logic                   rom_ok,

    output logic [obj_pxl_w-1:0]   pxl
);

    obj_draw_if drw_if ();

    logic [obj_prom_aw-1:0] pal_addr;
    logic [obj_pxl_w-1:0]   pal_colour;
    logic                   buf_we;
    logic [obj_buf_aw-1:0]  buf_addr;
    logic [obj_pxl_w-1:0]   buf_data;

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .hinit    (hinit),
        .vdump    (vdump),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .drw      (drw_if.scan)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .drw        (drw_if.drawer),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pal_colour (pal_colour),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .pal_addr   (pal_addr),
        .buf_we     (buf_we),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data)
    );

    obj_pal_prom u_prom (
        .clk        (clk),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pal_addr   (pal_addr),
        .pal_colour (pal_colour)
    );

    obj_line_buf u_buf (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hinit    (hinit),
        .lhbl     (lhbl),
        .hdump    (hdump),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .pxl      (pxl)
    );

endmodule

// File: sim/obj_rom_model.sv
module obj_rom_model import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [obj_rom_aw-1:0] rom_addr,
    input  logic                  rom_cs,
    input  logic [2:0]            latency,    // clocks from cs to ok, 1 to 4
    output logic [obj_rom_dw-1:0] rom_data,
    output logic                  rom_ok
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] cnt;        // clocks spent on the current request
    logic [2:0] lat_cur;
    logic [2:0] need;

    // word contents mixed from the whole address
    function automatic logic [obj_rom_dw-1:0] rom_word(input logic [obj_rom_aw-1:0] addr);
        logic [31:0] h;
        h = {18'b0, addr} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return h;
    endfunction

    assign need = (cnt == 3'd0) ? latency : lat_cur;

    always @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_data <= '0;
            cnt      <= '0;
            lat_cur  <= 3'd1;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;     // word taken on this clock
        end else if (rom_cs) begin
            if (cnt == 3'd0) begin
                lat_cur <= latency;
            end
            if (cnt + 3'd1 >= need) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
                cnt      <= '0;
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

endmodule

// File: sim/obj_render_tb.sv
module obj_render_tb import obj_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] seed = 32'h21b9db64;
    localparam int wait_limit = 4 * 384 * 60;

    logic                   clk;
    logic                   rst;
    logic                   tbl_we;
    logic [obj_tbl_aw-1:0]  tbl_addr;
    logic [obj_tbl_dw-1:0]  tbl_data;
    logic                   prog_en;
    logic [obj_prom_aw-1:0] prog_addr;
    logic [obj_pxl_w-1:0]   prog_data;
    logic                   pxl_cen;
    logic                   hinit;
    logic                   lhbl;
    logic [8:0]             hdump;
    logic [obj_pos_w-1:0]   vdump;
    logic [obj_rom_aw-1:0]  rom_addr;
    logic                   rom_cs;
    logic [obj_rom_dw-1:0]  rom_data;
    logic                   rom_ok;
    logic [obj_pxl_w-1:0]   pxl;
    logic [2:0]             rom_lat;

    logic [31:0]          rng_state;
    logic [31:0]          lat_state;
    logic                 video_on;
    int                   cyc;
    int                   hcnt;
    int                   vcnt;
    int                   lines_checked;
    logic                 last_cs;          // ROM bus one clock back
    logic                 last_ok;
    logic [obj_rom_aw-1:0] last_addr;
    logic [3:0]           expected;
    logic [3:0]           shown [256];      // image being read out
    logic [3:0]           pending [256];    // image being drawn
    logic [3:0]           prom_copy [256];
    logic [31:0]          tbl_copy [obj_count];

    obj_render obj_render_inst (
        .clk       (clk),
        .rst       (rst),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pxl_cen   (pxl_cen),
        .hinit     (hinit),
        .lhbl      (lhbl),
        .hdump     (hdump),
        .vdump     (vdump),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pxl       (pxl)
    );

    obj_rom_model rom_inst (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .latency  (rom_lat),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    // same hash as the ROM holds, packed nibbles with pixel 0 at bits 3:0
    function automatic logic [31:0] expected_word(input logic [obj_rom_aw-1:0] addr);
        logic [31:0] h;
        h = {18'b0, addr} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return h;
    endfunction

    // objects in table order, later ones paint over earlier ones
    task automatic paint_line(input logic [7:0] line);
        logic [31:0] entry;
        logic [7:0]  diff;
        logic [3:0]  row;
        logic [31:0] w;
        logic [3:0]  nib;
        logic [3:0]  c;
        logic [7:0]  addr;
        int          p;
        for (int e = 0; e < obj_count; e++) begin
            entry = tbl_copy[e];
            diff  = line - entry[obj_y_lsb +: 8];
            if (diff < 8'(obj_height)) begin
                row = entry[obj_vflip_bit] ? ~diff[3:0] : diff[3:0];
                for (int half = 0; half < 2; half++) begin
                    w = expected_word({entry[obj_code_lsb +: obj_code_w], row, 1'(half)});
                    for (int k = 0; k < 8; k++) begin
                        p    = half * 8 + k;
                        nib  = w[4*k +: 4];
                        c    = prom_copy[{entry[obj_pal_lsb +: obj_pal_w], nib}];
                        addr = entry[obj_x_lsb +: 8] + 8'(obj_hoffset)
                             + (entry[obj_hflip_bit] ? 8'(15 - p) : 8'(p));
                        if (c != 4'd0) begin
                            pending[addr] = c;   // colour 0 lets the old pixel through
                        end
                    end
                end
            end
        end
    endtask

    // video timing and pixel checks
    always @(negedge clk) begin
        if (video_on) begin
            if (hinit) begin
                for (int i = 0; i < 256; i++) begin
                    shown[i]   = pending[i];
                    pending[i] = 4'd0;
                end
                paint_line(vdump + 8'd1);
            end
            // a pending ROM request keeps cs and its address until rom_ok
            if (last_cs && !last_ok) begin
                assert (rom_cs && rom_addr == last_addr) else begin
                    $display("Error: %0t ns rom_cs %0b rom_addr %0h while %0h was pending",
                             $time, rom_cs, rom_addr, last_addr);
                    $display("Simulation failed");
                    $fatal(1, "ROM request not held");
                end
            end
            last_cs   = rom_cs;
            last_ok   = rom_ok;
            last_addr = rom_addr;
            if (pxl_cen && lhbl) begin
                // the read at hdump 0 still hits the bank just cleared
                expected = (hdump == 9'd0) ? 4'd0 : shown[hdump[7:0]];
                assert (pxl == expected) else begin
                    $display("Error: %0t ns pxl %0h expected %0h at hdump %0d vdump %0d",
                             $time, pxl, expected, hdump, vdump);
                    $display("Simulation failed");
                    $fatal(1, "pixel mismatch");
                end
                if (hdump == 9'd255) begin
                    lines_checked++;
                end
            end
            pxl_cen = (cyc == 0);
            hinit   = (cyc == 0) && (hcnt == 0);
            lhbl    = hcnt < 256;
            hdump   = 9'(hcnt);
            vdump   = 8'(vcnt);
            cyc++;
            if (cyc == 4) begin
                cyc = 0;
                hcnt++;
                if (hcnt == 384) begin
                    hcnt = 0;
                    vcnt++;
                end
            end
            lat_state = lcg_step(lat_state);
            rom_lat   = 3'(1 + lat_state[29:28]);
        end
    end

    // mode 0 and 1 keep 20 entries in one band, mode 2 moves all away
    task automatic write_table(input int mode);
        logic [31:0] r;
        logic [7:0]  y;
        for (int e = 0; e < obj_count; e++) begin
            r = next_rand();
            case (mode)
                0:       y = (e < 20) ? 8'(r % 24) : 8'(128 + r % 24);
                1:       y = (e < 20) ? 8'(16 + r % 24) : 8'(150 + r % 24);
                default: y = 8'(100 + r % 100);
            endcase
            r = next_rand();
            @(negedge clk);
            tbl_we      = 1'b1;
            tbl_addr    = 5'(e);
            tbl_data    = {1'b0, r[30], r[29], r[28:25], r[24:16], r[15:8], y};
            tbl_copy[e] = tbl_data;
        end
        @(negedge clk);
        tbl_we = 1'b0;
    endtask

    task automatic wait_for_position(input int v, input int h);
        logic found;
        found = 1'b0;
        for (int n = 0; n < wait_limit && !found; n++) begin
            @(posedge clk);
            if (vdump == 8'(v) && hdump == 9'(h)) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Simulation failed");
            $fatal(1, "timed out waiting for line %0d", v);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic        done;
        rng_state     = seed;
        lat_state     = seed ^ 32'h5a5a5a5a;
        video_on      = 1'b0;
        cyc           = 0;
        hcnt          = 0;
        vcnt          = 0;
        lines_checked = 0;
        last_cs       = 1'b0;
        last_ok       = 1'b0;
        last_addr     = '0;
        rst           = 1'b1;
        tbl_we        = 1'b0;
        tbl_addr      = '0;
        tbl_data      = '0;
        prog_en       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        pxl_cen       = 1'b0;
        hinit         = 1'b0;
        lhbl          = 1'b0;
        hdump         = '0;
        vdump         = '0;
        rom_lat       = 3'd1;
        for (int i = 0; i < 256; i++) begin
            shown[i]   = 4'd0;
            pending[i] = 4'd0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // random colours with plenty of transparent entries
        for (int i = 0; i < 256; i++) begin
            r = next_rand();
            @(negedge clk);
            prog_en      = 1'b1;
            prog_addr    = 8'(i);
            prog_data    = (r[31:30] == 2'd0) ? 4'd0 : r[27:24];
            prom_copy[i] = prog_data;
        end
        @(negedge clk);
        prog_en = 1'b0;

        write_table(0);
        video_on = 1'b1;

        wait_for_position(20, 300);     // scan of this line is long done
        write_table(1);
        wait_for_position(30, 300);
        write_table(2);                 // line 32 must come out empty

        done = 1'b0;
        for (int n = 0; n < wait_limit && !done; n++) begin
            @(posedge clk);
            done = lines_checked >= 40;
        end
        if (!done) begin
            $display("Simulation failed");
            $fatal(1, "timed out before 40 lines were checked");
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tb.f
src/obj_pkg.sv
src/obj_draw_if.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_pal_prom.sv
src/obj_line_buf.sv
src/obj_render.sv
sim/obj_rom_model.sv
sim/obj_render_tb.sv
